// ==== bev_pkg.sv ====
// Shared widths, enums, violation bit positions and register addresses for the checker and its testbench.
`default_nettype none

package bev_pkg;

    typedef enum logic [1:0] {
        MAKE_DRINK = 2'd0,
        SUPPLY     = 2'd1,
        CHECK_DATE = 2'd2
    } action_e;

    typedef enum logic [2:0] {
        BLACK_TEA,
        MILK_TEA,
        EXTRA_MILK_TEA,
        GREEN_TEA,
        GREEN_MILK_TEA,
        PINEAPPLE_JUICE,
        SUPER_PINEAPPLE_TEA,
        SUPER_PINEAPPLE_MILK_TEA
    } bev_type_e;

    typedef logic [1:0] bev_size_t;        // 0 = L, 1 = M, 2 = S, 3 is unused.

    typedef enum logic [1:0] {
        NO_ERR,
        NO_EXP,
        NO_ING,
        ING_OF
    } err_msg_e;

    typedef logic [3:0]  month_t;
    typedef logic [4:0]  day_t;
    typedef logic [7:0]  viol_vec_t;
    typedef logic [3:0]  wb_addr_t;
    typedef logic [15:0] wb_data_t;

    // Bit positions in the sticky violation register.
    localparam int V_OVERLAP   = 0;
    localparam int V_ORDER     = 1;
    localparam int V_GAP       = 2;
    localparam int V_DATE      = 3;
    localparam int V_LATENCY   = 4;
    localparam int V_OUT_WIDTH = 5;
    localparam int V_REQ_WIDTH = 6;
    localparam int V_REQ_AGAIN = 7;

    // Word addresses of the host register map.
    localparam wb_addr_t ADDR_VIOL      = 4'd0;
    localparam wb_addr_t ADDR_TYPE_BASE = 4'd1;
    localparam wb_addr_t ADDR_SIZE_BASE = 4'd9;
    localparam wb_addr_t ADDR_ERR_BASE  = 4'd12;

    localparam int NUM_CNT = 15;           // Eight types, three sizes, four result codes.

endpackage

`default_nettype wire

// ==== date_checker.sv ====
// Flags a sampled date whose month or day lies outside the calendar, as a one-cycle registered pulse.
`default_nettype none
`timescale 1ns/1ps

module date_checker (
    input  logic             clk,
    input  logic             inf,
    input  logic             date_valid,
    input  bev_pkg::month_t  d_month,
    input  bev_pkg::day_t    d_day,
    output logic             date_bad
);
    import bev_pkg::*;

    day_t day_limit;
    logic bad_now;

    // February never has a leap day here.
    always_comb begin
        case (d_month)
            4'd2:                      day_limit = 5'd28;
            4'd4, 4'd6, 4'd9, 4'd11:   day_limit = 5'd30;
            default:                   day_limit = 5'd31;
        endcase
    end

    assign bad_now = (d_month == 4'd0) || (d_month > 4'd12) ||
                     (d_day == 5'd0) || (d_day > day_limit);

    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            date_bad <= 1'b0;
        end else begin
            date_bad <= date_valid && bad_now;  // Only sampled dates count.
        end
    end

endmodule

`default_nettype wire

// ==== input_sequence_monitor.sv ====
// Follows each operation's input order and timing, and reports overlaps, order and gap errors.
`default_nettype none
`timescale 1ns/1ps

module input_sequence_monitor #(
    parameter int MAX_GAP      = 4,
    parameter int SUPPLY_BOXES = 4
) (
    input  logic              clk,
    input  logic              inf,
    input  logic              action_valid,
    input  logic              type_valid,
    input  logic              size_valid,
    input  logic              date_valid,
    input  logic              box_no_valid,
    input  logic              box_sup_valid,
    input  bev_pkg::action_e  d_act,
    input  logic              out_valid,
    output logic              op_end,
    output logic              overlap_err,
    output logic              order_err,
    output logic              gap_err
);
    import bev_pkg::*;

    localparam int GAP_W = $clog2(MAX_GAP + 1);
    localparam int SUP_W = $clog2(SUPPLY_BOXES + 1);

    typedef enum logic [2:0] {
        IDLE, WAIT_TYPE, WAIT_SIZE, WAIT_DATE, WAIT_BOX, WAIT_SUP, WAIT_OUT
    } seq_state_e;

    seq_state_e       state, state_n;
    action_e          act_q, act_n;
    logic [GAP_W-1:0] gap_cnt, gap_n;
    logic [SUP_W-1:0] sup_cnt, sup_n;
    logic             armed, armed_n;
    logic             end_n, ovl_n, ord_n, gap_err_n;
    logic [5:0]       valids;
    logic             exp_ok;
    logic             waiting;

    assign valids = {action_valid, type_valid, size_valid, date_valid,
                     box_no_valid, box_sup_valid};
    // The gap timer runs between inputs, and after a result until the next action.
    assign waiting = (state inside {WAIT_TYPE, WAIT_SIZE, WAIT_DATE, WAIT_BOX, WAIT_SUP}) ||
                     (state == IDLE && armed);

    always_comb begin
        case (state)
            IDLE:      exp_ok = action_valid;
            WAIT_TYPE: exp_ok = type_valid;
            WAIT_SIZE: exp_ok = size_valid;
            WAIT_DATE: exp_ok = date_valid;
            WAIT_BOX:  exp_ok = box_no_valid;
            WAIT_SUP:  exp_ok = box_sup_valid;
            default:   exp_ok = 1'b0;           // No input is due while a result is pending.
        endcase
    end

    always_comb begin
        state_n   = state;
        act_n     = act_q;
        gap_n     = gap_cnt;
        sup_n     = sup_cnt;
        armed_n   = armed;
        end_n     = 1'b0;
        ovl_n     = 1'b0;
        ord_n     = 1'b0;
        gap_err_n = 1'b0;
        if (!$onehot0(valids)) begin
            ovl_n = 1'b1;                       // State holds, but the input resets the timer.
            gap_n = '0;
        end else if (|valids) begin
            gap_n   = '0;
            armed_n = 1'b0;
            ord_n   = !exp_ok;
            if (action_valid) begin
                act_n   = d_act;
                state_n = (d_act == MAKE_DRINK) ? WAIT_TYPE : WAIT_DATE;
            end else if (!exp_ok) begin
                state_n = IDLE;
            end else begin
                case (state)
                    WAIT_TYPE: state_n = WAIT_SIZE;
                    WAIT_SIZE: state_n = WAIT_DATE;
                    WAIT_DATE: state_n = WAIT_BOX;
                    WAIT_BOX: begin
                        sup_n   = '0;
                        state_n = (act_q == SUPPLY) ? WAIT_SUP : WAIT_OUT;
                        end_n   = (act_q != SUPPLY);
                    end
                    default: begin
                        if (sup_cnt == SUP_W'(SUPPLY_BOXES - 1)) begin
                            state_n = WAIT_OUT;
                            end_n   = 1'b1;
                        end else begin
                            sup_n = sup_cnt + 1'b1;
                        end
                    end
                endcase
            end
        end else if (out_valid) begin
            state_n = IDLE;
            armed_n = 1'b1;
            gap_n   = '0;
        end else if (waiting) begin
            if (gap_cnt == GAP_W'(MAX_GAP - 1)) begin
                gap_err_n = 1'b1;               // Abandon the operation.
                state_n   = IDLE;
                armed_n   = 1'b0;
                gap_n     = '0;
            end else begin
                gap_n = gap_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            state       <= IDLE;
            act_q       <= MAKE_DRINK;
            gap_cnt     <= '0;
            sup_cnt     <= '0;
            armed       <= 1'b0;
            op_end      <= 1'b0;
            overlap_err <= 1'b0;
            order_err   <= 1'b0;
            gap_err     <= 1'b0;
        end else begin
            state       <= state_n;
            act_q       <= act_n;
            gap_cnt     <= gap_n;
            sup_cnt     <= sup_n;
            armed       <= armed_n;
            op_end      <= end_n;
            overlap_err <= ovl_n;
            order_err   <= ord_n;
            gap_err     <= gap_err_n;
        end
    end

    a_state_legal: assert property (@(posedge clk) disable iff (!inf)
        state inside {IDLE, WAIT_TYPE, WAIT_SIZE, WAIT_DATE, WAIT_BOX, WAIT_SUP, WAIT_OUT});

endmodule

`default_nettype wire

// ==== op_latency_monitor.sv ====
// Times each result against the end of its operation and checks that the result strobe lasts one cycle.
`default_nettype none
`timescale 1ns/1ps

module op_latency_monitor #(
    parameter int MAX_LATENCY = 1000
) (
    input  logic clk,
    input  logic inf,
    input  logic op_end,
    input  logic out_valid,
    output logic latency_err,
    output logic out_width_err
);
    localparam int LAT_W = $clog2(MAX_LATENCY + 1);

    logic             running;
    logic [LAT_W-1:0] lat_cnt;
    logic             out_q;

    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            running       <= 1'b0;
            lat_cnt       <= '0;
            latency_err   <= 1'b0;
            out_q         <= 1'b0;
            out_width_err <= 1'b0;
        end else begin
            latency_err   <= 1'b0;
            out_q         <= out_valid;
            out_width_err <= out_valid && out_q;    // High on two cycles in a row.
            // A result in the same cycle as op_end needs no timer.
            if (op_end && !out_valid) begin
                running <= 1'b1;
                lat_cnt <= '0;
            end else if (running) begin
                if (out_valid) begin
                    running <= 1'b0;
                end else if (lat_cnt == LAT_W'(MAX_LATENCY - 1)) begin
                    running     <= 1'b0;            // Report once; a late result passes quietly.
                    latency_err <= 1'b1;
                end else begin
                    lat_cnt <= lat_cnt + 1'b1;
                end
            end
        end
    end

    // The sequence monitor must not close a new operation before the last one was answered.
    a_no_overlapping_ops: assert property (@(posedge clk) disable iff (!inf)
        op_end |-> !running);

endmodule

`default_nettype wire

// ==== dram_request_monitor.sv ====
// Checks that each memory request lasts one cycle and is not reissued before its reply.
`default_nettype none
`timescale 1ns/1ps

module dram_request_monitor (
    input  logic clk,
    input  logic inf,
    input  logic c_in_valid,
    input  logic c_out_valid,
    output logic req_width_err,
    output logic req_again_err
);
    logic busy;     // A request is outstanding.
    logic in_q;

    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            busy          <= 1'b0;
            in_q          <= 1'b0;
            req_width_err <= 1'b0;
            req_again_err <= 1'b0;
        end else begin
            in_q          <= c_in_valid;
            req_width_err <= c_in_valid && in_q;
            // The second cycle of a wide request is not a new request.
            req_again_err <= c_in_valid && !in_q && busy;
            if (c_in_valid) begin
                busy <= 1'b1;
            end else if (c_out_valid) begin
                busy <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== coverage_counters.sv ====
// Saturating occurrence counters for beverage type, beverage size and result code, in register map order.
`default_nettype none
`timescale 1ns/1ps

module coverage_counters #(
    parameter int CNT_W = 16
) (
    input  logic                              clk,
    input  logic                              inf,
    input  logic                              type_valid,
    input  bev_pkg::bev_type_e                d_type,
    input  logic                              size_valid,
    input  bev_pkg::bev_size_t                d_size,
    input  logic                              out_valid,
    input  bev_pkg::err_msg_e                 err_msg,
    output logic [bev_pkg::NUM_CNT*CNT_W-1:0] cnt_flat
);
    import bev_pkg::*;

    // Counter index equals word address minus the first counter address.
    localparam int SIZE_OFS = int'(ADDR_SIZE_BASE) - int'(ADDR_TYPE_BASE);
    localparam int ERR_OFS  = int'(ADDR_ERR_BASE) - int'(ADDR_TYPE_BASE);

    logic [NUM_CNT-1:0] inc;
    logic [CNT_W-1:0]   cnt [NUM_CNT];

    always_comb begin
        inc = '0;
        if (type_valid) begin
            inc[int'(d_type)] = 1'b1;
        end
        if (size_valid && d_size != 2'd3) begin        // The unused size code counts nowhere.
            inc[SIZE_OFS + int'(d_size)] = 1'b1;
        end
        if (out_valid) begin
            inc[ERR_OFS + int'(err_msg)] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            for (int i = 0; i < NUM_CNT; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_CNT; i++) begin
                if (inc[i] && cnt[i] != '1) begin
                    cnt[i] <= cnt[i] + 1'b1;   // Hold at the top value.
                end
            end
        end
    end

    for (genvar g = 0; g < NUM_CNT; g++) begin : g_cnt
        assign cnt_flat[g*CNT_W +: CNT_W] = cnt[g];

        a_no_decrease: assert property (@(posedge clk) disable iff (!inf)
            cnt[g] >= $past(cnt[g]));
    end

endmodule

`default_nettype wire

// ==== wb_status_regs.sv ====
// Wishbone classic slave holding the sticky violation register and the read map of the counters.
`default_nettype none
`timescale 1ns/1ps

module wb_status_regs #(
    parameter int CNT_W = 16
) (
    input  logic                              clk,
    input  logic                              inf,
    input  logic                              wb_cyc,
    input  logic                              wb_stb,
    input  logic                              wb_we,
    input  bev_pkg::wb_addr_t                 wb_adr,
    input  bev_pkg::wb_data_t                 wb_dat_w,
    output bev_pkg::wb_data_t                 wb_dat_r,
    output logic                              wb_ack,
    input  bev_pkg::viol_vec_t                viol_pulse,
    input  logic [bev_pkg::NUM_CNT*CNT_W-1:0] cnt_flat,
    output logic                              violation
);
    import bev_pkg::*;

    viol_vec_t sticky;
    viol_vec_t clr;
    wb_data_t  rd_data;
    logic      req;
    int        cnt_idx;

    assign req = wb_cyc && wb_stb && !wb_ack;   // First cycle of a transfer.
    assign clr = (req && wb_we && wb_adr == ADDR_VIOL) ? viol_vec_t'(wb_dat_w) : '0;
    assign cnt_idx = int'(wb_adr) - int'(ADDR_TYPE_BASE);

    always_comb begin
        rd_data = '0;
        if (wb_adr == ADDR_VIOL) begin
            rd_data = wb_data_t'(sticky);
        end else if (cnt_idx >= 0 && cnt_idx < NUM_CNT) begin
            rd_data = wb_data_t'(cnt_flat[cnt_idx*CNT_W +: CNT_W]);
        end
    end

    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            sticky   <= '0;
            wb_ack   <= 1'b0;
            wb_dat_r <= '0;
        end else begin
            // A new pulse wins over a clear of the same bit.
            sticky <= (sticky & ~clr) | viol_pulse;
            wb_ack <= req;
            if (req) begin
                wb_dat_r <= rd_data;
            end
        end
    end

    assign violation = |sticky;

    a_ack_single: assert property (@(posedge clk) disable iff (!inf)
        wb_ack |=> !wb_ack);

endmodule

`default_nettype wire

// ==== bev_protocol_checker.sv ====
// Protocol checker top level; sits beside the beverage controller and is read over Wishbone.
`default_nettype none
`timescale 1ns/1ps

module bev_protocol_checker #(
    parameter int MAX_GAP      = 4,
    parameter int MAX_LATENCY  = 1000,
    parameter int SUPPLY_BOXES = 4,
    parameter int CNT_W        = 16
) (
    input  logic                clk,
    input  logic                inf,
    input  logic                action_valid,
    input  bev_pkg::action_e    d_act,
    input  logic                type_valid,
    input  bev_pkg::bev_type_e  d_type,
    input  logic                size_valid,
    input  bev_pkg::bev_size_t  d_size,
    input  logic                date_valid,
    input  bev_pkg::month_t     d_month,
    input  bev_pkg::day_t       d_day,
    input  logic                box_no_valid,
    input  logic                box_sup_valid,
    input  logic                out_valid,
    input  bev_pkg::err_msg_e   err_msg,
    input  logic                c_in_valid,
    input  logic                c_out_valid,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  bev_pkg::wb_addr_t   wb_adr,
    input  bev_pkg::wb_data_t   wb_dat_w,
    output bev_pkg::wb_data_t   wb_dat_r,
    output logic                wb_ack,
    output logic                violation
);
    import bev_pkg::*;

    viol_vec_t                  viol_pulse;
    logic                       op_end;
    logic [NUM_CNT*CNT_W-1:0]   cnt_flat;

    date_checker u_date (
        .clk(clk), .inf(inf), .date_valid(date_valid), .d_month(d_month), .d_day(d_day),
        .date_bad(viol_pulse[V_DATE])
    );

    input_sequence_monitor #(.MAX_GAP(MAX_GAP), .SUPPLY_BOXES(SUPPLY_BOXES)) u_seq (
        .clk(clk), .inf(inf), .action_valid(action_valid), .type_valid(type_valid),
        .size_valid(size_valid), .date_valid(date_valid), .box_no_valid(box_no_valid),
        .box_sup_valid(box_sup_valid), .d_act(d_act), .out_valid(out_valid),
        .op_end(op_end), .overlap_err(viol_pulse[V_OVERLAP]),
        .order_err(viol_pulse[V_ORDER]), .gap_err(viol_pulse[V_GAP])
    );

    op_latency_monitor #(.MAX_LATENCY(MAX_LATENCY)) u_lat (
        .clk(clk), .inf(inf), .op_end(op_end), .out_valid(out_valid),
        .latency_err(viol_pulse[V_LATENCY]), .out_width_err(viol_pulse[V_OUT_WIDTH])
    );

    dram_request_monitor u_req (
        .clk(clk), .inf(inf), .c_in_valid(c_in_valid), .c_out_valid(c_out_valid),
        .req_width_err(viol_pulse[V_REQ_WIDTH]), .req_again_err(viol_pulse[V_REQ_AGAIN])
    );

    coverage_counters #(.CNT_W(CNT_W)) u_cov (
        .clk(clk), .inf(inf), .type_valid(type_valid), .d_type(d_type),
        .size_valid(size_valid), .d_size(d_size), .out_valid(out_valid),
        .err_msg(err_msg), .cnt_flat(cnt_flat)
    );

    wb_status_regs #(.CNT_W(CNT_W)) u_regs (
        .clk(clk), .inf(inf), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .viol_pulse(viol_pulse), .cnt_flat(cnt_flat), .violation(violation)
    );

endmodule

`default_nettype wire

// ==== tb_bev_checker.sv ====
// Random-stimulus testbench for the protocol checker that compares its registers with a model.
`default_nettype none
`timescale 1ns/1ps

module tb_bev_checker;
    import bev_pkg::*;

    localparam int CLK_PERIOD      = 100;
    localparam int MAX_GAP         = 4;
    localparam int MAX_LATENCY     = 40;
    localparam int SUPPLY_BOXES    = 4;
    localparam int LEGAL_OPS       = 60;
    localparam int OP_CYCLES       = 80;    // Longest legal operation with its result, plus margin.
    localparam int WATCHDOG_CYCLES = LEGAL_OPS * OP_CYCLES + 3000;
    localparam int SIZE_IDX        = int'(ADDR_SIZE_BASE) - int'(ADDR_TYPE_BASE);
    localparam int ERR_IDX         = int'(ADDR_ERR_BASE) - int'(ADDR_TYPE_BASE);

    logic       clk, inf;
    logic       action_valid, type_valid, size_valid, date_valid, box_no_valid, box_sup_valid;
    logic       out_valid, c_in_valid, c_out_valid;
    action_e    d_act;
    bev_type_e  d_type;
    bev_size_t  d_size;
    month_t     d_month;
    day_t       d_day;
    err_msg_e   err_msg;
    logic       wb_cyc, wb_stb, wb_we, wb_ack, violation;
    wb_addr_t   wb_adr;
    wb_data_t   wb_dat_w, wb_dat_r;

    // Model state.
    int         exp_cnt [NUM_CNT];
    viol_vec_t  exp_sticky;
    logic       gap_live;               // The checker is waiting for the next input.
    int         idle_cnt;
    logic       out_prev, cin_prev, req_busy;
    int         mismatches, failures;
    logic [15:0] lfsr_state;

    bev_protocol_checker #(.MAX_GAP(MAX_GAP), .MAX_LATENCY(MAX_LATENCY),
                           .SUPPLY_BOXES(SUPPLY_BOXES)) DUT (
        .clk(clk), .inf(inf), .action_valid(action_valid), .d_act(d_act),
        .type_valid(type_valid), .d_type(d_type), .size_valid(size_valid), .d_size(d_size),
        .date_valid(date_valid), .d_month(d_month), .d_day(d_day),
        .box_no_valid(box_no_valid), .box_sup_valid(box_sup_valid),
        .out_valid(out_valid), .err_msg(err_msg), .c_in_valid(c_in_valid),
        .c_out_valid(c_out_valid), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .violation(violation)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Taps 16, 14, 13 and 11 give a maximal-length sequence.
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = (v << 1) | int'(lfsr_state[0]);
        end
        return v;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + rand_bits(8) % (hi - lo + 1);
    endfunction

    function automatic int days_in_month(input int m);
        case (m)
            2:           return 28;
            4, 6, 9, 11: return 30;
            default:     return 31;
        endcase
    endfunction

    function automatic bit date_legal(input int m, input int d);
        return m >= 1 && m <= 12 && d >= 1 && d <= days_in_month(m);
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            mismatches++;
            $display("mismatch %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        end
    endtask

    task automatic count_event(input int idx);
        if (exp_cnt[idx] < (1 << 16) - 1) begin
            exp_cnt[idx]++;             // Counters stop at their top value.
        end
    endtask

    // Updates the model from the inputs driven for this cycle, then advances one clock.
    task automatic clock_cycle();
        int nvalid;
        nvalid = int'(action_valid) + int'(type_valid) + int'(size_valid) + int'(date_valid) +
                 int'(box_no_valid) + int'(box_sup_valid);
        if (nvalid > 1) begin
            exp_sticky[V_OVERLAP] = 1'b1;
        end
        if (date_valid && !date_legal(int'(d_month), int'(d_day))) begin
            exp_sticky[V_DATE] = 1'b1;
        end
        if (out_valid && out_prev) begin
            exp_sticky[V_OUT_WIDTH] = 1'b1;
        end
        if (c_in_valid && cin_prev) begin
            exp_sticky[V_REQ_WIDTH] = 1'b1;
        end
        if (c_in_valid && !cin_prev && req_busy) begin
            exp_sticky[V_REQ_AGAIN] = 1'b1;
        end
        if (c_in_valid) begin
            req_busy = 1'b1;
        end else if (c_out_valid) begin
            req_busy = 1'b0;
        end
        if (type_valid) begin
            count_event(int'(d_type));
        end
        if (size_valid && int'(d_size) != 3) begin
            count_event(SIZE_IDX + int'(d_size));
        end
        if (out_valid) begin
            count_event(ERR_IDX + int'(err_msg));
        end
        if (nvalid > 0) begin
            idle_cnt = 0;
        end else if (out_valid) begin
            gap_live = 1'b1;            // The next action is now due.
            idle_cnt = 0;
        end else if (gap_live) begin
            idle_cnt++;
            if (idle_cnt == MAX_GAP) begin
                exp_sticky[V_GAP] = 1'b1;
                gap_live = 1'b0;
                idle_cnt = 0;
            end
        end
        out_prev = out_valid;
        cin_prev = c_in_valid;
        @(posedge clk);
        #1;
    endtask

    task automatic idle(input int n);
        repeat (n) clock_cycle();
    endtask

    task automatic clear_valids();
        action_valid  = 1'b0;
        type_valid    = 1'b0;
        size_valid    = 1'b0;
        date_valid    = 1'b0;
        box_no_valid  = 1'b0;
        box_sup_valid = 1'b0;
    endtask

    // Drives one input valid for a cycle; ends_wait says the checker stops waiting for inputs.
    task automatic send_input(input int idx, input bit ends_wait);
        case (idx)
            0:       action_valid = 1'b1;
            1:       type_valid = 1'b1;
            2:       size_valid = 1'b1;
            3:       date_valid = 1'b1;
            4:       box_no_valid = 1'b1;
            default: box_sup_valid = 1'b1;
        endcase
        gap_live = !ends_wait;
        clock_cycle();
        clear_valids();
    endtask

    task automatic run_operation(input action_e act, input int delay, input int width,
                                 input bit bad_date);
        int m;
        int d;
        d_act = act;
        send_input(0, 1'b0);
        if (act == MAKE_DRINK) begin
            idle(rand_range(0, MAX_GAP - 1));
            d_type = bev_type_e'(rand_bits(3));
            send_input(1, 1'b0);
            idle(rand_range(0, MAX_GAP - 1));
            d_size = bev_size_t'(rand_bits(2));
            send_input(2, 1'b0);
        end
        m = rand_range(1, 12);
        d = rand_range(1, days_in_month(m));
        if (bad_date) begin
            case (rand_bits(2))
                0:       m = 0;
                1:       m = rand_range(13, 15);
                2:       d = 0;
                default: begin
                    m = (rand_bits(1) == 1) ? 2 : 4;
                    d = rand_range(days_in_month(m) + 1, 31);
                end
            endcase
        end
        idle(rand_range(0, MAX_GAP - 1));
        d_month = month_t'(m);
        d_day = day_t'(d);
        c_in_valid = 1'b1;              // The controller reads memory as the date arrives.
        send_input(3, 1'b0);
        c_in_valid = 1'b0;
        idle(rand_range(0, MAX_GAP - 1));
        c_out_valid = 1'b1;
        send_input(4, act != SUPPLY);
        c_out_valid = 1'b0;
        if (act == SUPPLY) begin
            for (int i = 0; i < SUPPLY_BOXES; i++) begin
                idle(rand_range(0, MAX_GAP - 1));
                send_input(5, i == SUPPLY_BOXES - 1);
            end
        end
        if (delay > MAX_LATENCY) begin
            exp_sticky[V_LATENCY] = 1'b1;   // The result misses its deadline.
        end
        idle(delay - 1);
        for (int i = 0; i < width; i++) begin
            out_valid = 1'b1;
            err_msg = err_msg_e'(rand_bits(2));
            clock_cycle();
        end
        out_valid = 1'b0;
    endtask

    task automatic wb_transfer(input bit we, input wb_addr_t adr, input wb_data_t wdata,
                               output wb_data_t rdata);
        int waited;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = adr;
        wb_dat_w = wdata;
        waited = 0;
        rdata = '0;
        do begin
            clock_cycle();
            waited++;
        end while (!wb_ack && waited < 16);
        if (!wb_ack) begin
            failures++;
            $display("Wishbone transfer to address %0d got no acknowledge", adr);
        end else begin
            check_value("wishbone ack delay", 1, waited);
            rdata = wb_dat_r;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        clock_cycle();
        check_value("wishbone ack width", 0, int'(wb_ack));
    endtask

    task automatic check_regs(input string name);
        wb_data_t rd;
        idle(8);                        // Lets pending pulses reach the sticky register.
        check_value({name, " violation"}, int'(|exp_sticky), int'(violation));
        wb_transfer(1'b0, ADDR_VIOL, '0, rd);
        check_value({name, " sticky"}, int'(exp_sticky), int'(rd));
        for (int i = 0; i < NUM_CNT; i++) begin
            wb_transfer(1'b0, wb_addr_t'(int'(ADDR_TYPE_BASE) + i), '0, rd);
            check_value($sformatf("%s counter %0d", name, i + 1), exp_cnt[i], int'(rd));
        end
    endtask

    // Writing the expected flags back clears exactly those bits.
    task automatic clear_flags(input string name);
        wb_data_t  rd;
        wb_data_t  unused;
        viol_vec_t wr;
        wr = exp_sticky;
        wb_transfer(1'b1, ADDR_VIOL, wb_data_t'(wr), unused);
        exp_sticky = exp_sticky & ~wr;
        check_value({name, " violation after clear"}, int'(|exp_sticky), int'(violation));
        wb_transfer(1'b0, ADDR_VIOL, '0, rd);
        check_value({name, " sticky after clear"}, int'(exp_sticky), int'(rd));
    endtask

    initial begin
        wb_data_t unused;
        lfsr_state = 16'd13389;
        mismatches = 0;
        failures = 0;
        inf = 1'b0;
        clear_valids();
        out_valid = 1'b0;
        c_in_valid = 1'b0;
        c_out_valid = 1'b0;
        d_act = MAKE_DRINK;
        d_type = BLACK_TEA;
        d_size = '0;
        d_month = '0;
        d_day = '0;
        err_msg = NO_ERR;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        for (int i = 0; i < NUM_CNT; i++) begin
            exp_cnt[i] = 0;
        end
        exp_sticky = '0;
        gap_live = 1'b0;
        idle_cnt = 0;
        out_prev = 1'b0;
        cin_prev = 1'b0;
        req_busy = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        inf = 1'b1;

        check_regs("reset");

        // A gap flag follows the idle time after the last result.
        for (int n = 0; n < LEGAL_OPS; n++) begin
            run_operation(action_e'(rand_range(0, 2)), rand_range(1, 30), 1, 1'b0);
            idle(rand_range(0, MAX_GAP - 1));
        end
        check_regs("legal traffic");
        clear_flags("legal traffic");

        run_operation(CHECK_DATE, rand_range(1, 30), 1, 1'b1);
        check_regs("calendar");
        clear_flags("calendar");

        d_act = MAKE_DRINK;
        d_type = bev_type_e'(rand_bits(3));
        action_valid = 1'b1;
        type_valid = 1'b1;
        clock_cycle();
        clear_valids();
        check_regs("overlap");
        clear_flags("overlap");

        d_act = MAKE_DRINK;
        send_input(0, 1'b0);
        d_size = bev_size_t'(rand_bits(2));
        exp_sticky[V_ORDER] = 1'b1;     // Size arrives where type is due.
        send_input(2, 1'b1);
        check_regs("order");
        clear_flags("order");

        d_act = action_e'(rand_range(0, 2));
        send_input(0, 1'b0);
        idle(MAX_GAP + 1);
        check_regs("gap");
        clear_flags("gap");

        run_operation(CHECK_DATE, MAX_LATENCY + 5, 1, 1'b0);
        check_regs("latency");
        clear_flags("latency");

        run_operation(action_e'(rand_range(0, 2)), rand_range(1, 30), 2, 1'b0);
        check_regs("result width");
        clear_flags("result width");

        c_in_valid = 1'b1;
        idle(2);
        c_in_valid = 1'b0;
        idle(2);
        c_out_valid = 1'b1;
        clock_cycle();
        c_out_valid = 1'b0;
        check_regs("request width");
        clear_flags("request width");

        c_in_valid = 1'b1;
        clock_cycle();
        c_in_valid = 1'b0;
        idle(2);
        c_in_valid = 1'b1;              // Second request with the first still open.
        clock_cycle();
        c_in_valid = 1'b0;
        idle(2);
        c_out_valid = 1'b1;
        clock_cycle();
        c_out_valid = 1'b0;
        check_regs("request again");
        clear_flags("request again");

        wb_transfer(1'b1, wb_addr_t'(5), 16'hffff, unused);
        check_regs("counter write");

        idle(4);
        $display("Checks finished with %0d mismatches and %0d other errors", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        failures++;
        $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("Checks finished with %0d mismatches and %0d other errors", mismatches, failures);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
bev_pkg.sv
date_checker.sv
input_sequence_monitor.sv
op_latency_monitor.sv
dram_request_monitor.sv
coverage_counters.sv
wb_status_regs.sv
bev_protocol_checker.sv
tb_bev_checker.sv
